// ==== rom_fetch_top.f ====
hw/rom_pkg.sv
hw/rom_slot_if.sv
hw/rom_cache.sv
hw/rom_arbiter.sv
hw/rom_fetch_top.sv
tb/sdram_model.sv
tb/rom_fetch_tb.sv

// ==== Bender.yml ====
package:
  name: rom_fetch

sources:
  # design, package first
  - hw/rom_pkg.sv
  - hw/rom_slot_if.sv
  - hw/rom_cache.sv
  - hw/rom_arbiter.sv
  - hw/rom_fetch_top.sv
  # simulation only
  - target: test
    files:
      - tb/sdram_model.sv
      - tb/rom_fetch_tb.sv

// ==== tb/rom_fetch_tb.sv ====
// rom fetch testbench: runs both rom clients against a modelled sdram and checks every read
`timescale 1ns/10ps

module rom_fetch_tb;
    import rom_pkg::*;

    localparam int          CLK_PERIOD = 8;
    localparam int          SEED       = 32'h3f7cc304;
    localparam int          READ_COUNT = 219;       // reads over all six tests
    localparam int          WAIT_LIMIT = 100;       // cycles a single read may take
    localparam sdram_addr_t OFFSET1    = 22'h10000; // graphics rom region start

    logic        clk;
    logic        rst;
    logic [17:0] rom0_addr;
    logic        rom0_addr_ok;
    logic [7:0]  rom0_data;
    logic        rom0_data_ok;
    logic [19:0] rom1_addr;
    logic        rom1_addr_ok;
    logic [15:0] rom1_data;
    logic        rom1_data_ok;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        sdram_ack;
    logic        sdram_rdy;
    word_t       sdram_dout;

    int          errors;
    int          checks;
    int          req_cnt [2];       // sdram requests taken, per slot
    sdram_addr_t last_addr [2];     // address of the latest one
    logic        cold [2];          // cache model still in init
    sdram_addr_t tag_a [2];         // model of entry 0
    sdram_addr_t tag_b [2];         // model of entry 1
    logic        victim [2];
    integer      seed;
    logic [31:0] r;
    logic [19:0] rnd0 [100];
    logic [19:0] rnd1 [100];
    logic        m0;
    logic        m1;

    rom_fetch_top uut (
        .clk          (clk),
        .rst          (rst),
        .rom0_addr    (rom0_addr),
        .rom0_addr_ok (rom0_addr_ok),
        .rom0_data    (rom0_data),
        .rom0_data_ok (rom0_data_ok),
        .rom1_addr    (rom1_addr),
        .rom1_addr_ok (rom1_addr_ok),
        .rom1_data    (rom1_data),
        .rom1_data_ok (rom1_data_ok),
        .sdram_req    (sdram_req),
        .sdram_addr   (sdram_addr),
        .sdram_ack    (sdram_ack),
        .sdram_rdy    (sdram_rdy),
        .sdram_dout   (sdram_dout)
    );

    sdram_model #(.SEED(SEED)) u_sdram (
        .clk  (clk),
        .rst  (rst),
        .req  (sdram_req),
        .addr (sdram_addr),
        .ack  (sdram_ack),
        .rdy  (sdram_rdy),
        .dout (sdram_dout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // count taken requests, the address tells which region asked
    always @(negedge clk) begin
        if (!rst && sdram_req && sdram_ack) begin
            if (sdram_addr >= OFFSET1) begin
                req_cnt[1]++;
                last_addr[1] = sdram_addr;
            end else begin
                req_cnt[0]++;
                last_addr[0] = sdram_addr;
            end
        end
    end

    // sdram request stays up with a steady address until taken
    req_hold: assert property (@(posedge clk) disable iff (rst)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else begin
            $display("sdram request dropped or moved before ack at %0t", $time);
            errors++;
        end

    req_drop: assert property (@(posedge clk) disable iff (rst)
        sdram_req && sdram_ack |=> !sdram_req)
        else begin
            $display("sdram request still high after ack at %0t", $time);
            errors++;
        end

    ok0_pulse: assert property (@(posedge clk) disable iff (rst)
        rom0_data_ok |=> !rom0_data_ok)
        else begin
            $display("slot 0 data_ok longer than one cycle at %0t", $time);
            errors++;
        end

    ok1_pulse: assert property (@(posedge clk) disable iff (rst)
        rom1_data_ok |=> !rom1_data_ok)
        else begin
            $display("slot 1 data_ok longer than one cycle at %0t", $time);
            errors++;
        end

    // word held at an sdram address
    function automatic word_t expected_word(input sdram_addr_t wa);
        word_t w;
        w = word_t'(wa);
        return (w ^ 32'h5a5a0000) + (w << 10);
    endfunction

    // one client read, called 1 ns after a rising edge, returns whether sdram was used
    task automatic read_slot(input int s, input logic [19:0] a, output logic missed);
        sdram_addr_t wa;
        word_t       w;
        logic [15:0] exp_val;
        logic [15:0] got;
        logic        pred_miss;
        logic        seen;
        int          base;
        int          lat;
        if (s == 0) begin                           // byte rom, 4 bytes per word
            wa      = sdram_addr_t'(a[17:2]);
            w       = expected_word(wa);
            exp_val = {8'd0, w[8 * a[1:0] +: 8]};
        end else begin                              // halfword rom, 2 per word
            wa      = sdram_addr_t'(a[19:1]) + OFFSET1;
            w       = expected_word(wa);
            exp_val = a[0] ? w[31:16] : w[15:0];
        end
        pred_miss = cold[s] || (wa != tag_a[s] && wa != tag_b[s]);
        base      = req_cnt[s];
        if (s == 0) begin
            rom0_addr    = a[17:0];
            rom0_addr_ok = 1'b1;
        end else begin
            rom1_addr    = a;
            rom1_addr_ok = 1'b1;
        end
        lat  = 0;
        seen = 1'b0;
        got  = '0;
        while (!seen && lat < WAIT_LIMIT) begin
            @(negedge clk);
            if (s == 0 && rom0_data_ok) begin
                seen = 1'b1;
                got  = {8'd0, rom0_data};
            end else if (s == 1 && rom1_data_ok) begin
                seen = 1'b1;
                got  = rom1_data;
            end else begin
                lat++;                              // rising edges before data_ok
            end
        end
        @(posedge clk);
        #1;
        if (s == 0) rom0_addr_ok = 1'b0;
        else rom1_addr_ok = 1'b0;
        missed = (req_cnt[s] != base);
        checks++;
        assert (seen) else begin
            $display("slot %0d read of %h never returned data_ok", s, a);
            errors++;
        end
        if (!seen) return;
        checks += 4;
        assert (req_cnt[s] - base == (pred_miss ? 1 : 0)) else begin
            $display("Mismatch at %0t: slot %0d addr %h made %0d sdram requests, expected %0d",
                     $time, s, a, req_cnt[s] - base, pred_miss ? 1 : 0);
            errors++;
        end
        assert (!pred_miss || last_addr[s] == wa) else begin
            $display("Mismatch at %0t: slot %0d addr %h fetched sdram %h, expected %h",
                     $time, s, a, last_addr[s], wa);
            errors++;
        end
        assert (pred_miss || lat == 1) else begin
            $display("Mismatch at %0t: slot %0d hit on %h took %0d cycles, expected 1",
                     $time, s, a, lat);
            errors++;
        end
        assert (got == exp_val) else begin
            $display("Mismatch at %0t: slot %0d addr %h data %h, expected %h",
                     $time, s, a, got, exp_val);
            errors++;
        end
        if (pred_miss) begin                        // alternate fill, first one loads both
            if (cold[s]) begin
                tag_a[s] = wa;
                tag_b[s] = wa;
                cold[s]  = 1'b0;
            end else if (!victim[s]) begin
                tag_a[s]  = wa;
                victim[s] = 1'b1;
            end else begin
                tag_b[s]  = wa;
                victim[s] = 1'b0;
            end
        end
        @(posedge clk);                             // one idle cycle between reads
        #1;
    endtask

    // simple pass/fail flag for one expected outcome
    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s at %0t", what, $time);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
        end
    endtask

    initial begin
        int e;
        seed   = SEED;
        errors = 0;
        checks = 0;
        for (int i = 0; i < 2; i++) begin
            req_cnt[i]   = 0;
            last_addr[i] = '0;
            cold[i]      = 1'b1;
            tag_a[i]     = '0;
            tag_b[i]     = '0;
            victim[i]    = 1'b0;
        end
        rst          = 1'b1;
        rom0_addr    = '0;
        rom0_addr_ok = 1'b0;
        rom1_addr    = '0;
        rom1_addr_ok = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        // reset state, then word 0 must still go to sdram
        e = errors;
        @(negedge clk);
        expect_true(!sdram_req && !rom0_data_ok && !rom1_data_ok, "outputs busy after reset");
        @(posedge clk);
        #1;
        read_slot(0, 20'h0, m0);
        read_slot(1, 20'h0, m1);
        expect_true(m0 && m1, "first access after reset did not reach sdram");
        report_test(1, "reset and first access", e);

        // every byte lane and both halfwords, each on a fresh word
        e = errors;
        read_slot(0, {2'b00, 16'h0100, 2'd0}, m0);
        read_slot(0, {2'b00, 16'h0201, 2'd1}, m0);
        read_slot(0, {2'b00, 16'h0302, 2'd2}, m0);
        read_slot(0, {2'b00, 16'h0403, 2'd3}, m0);
        read_slot(1, {19'h2a000, 1'b0}, m1);
        read_slot(1, {19'h7ffff, 1'b1}, m1);        // top of the graphics region
        report_test(2, "miss data and sdram address", e);

        // both cached words of each slot again
        e = errors;
        read_slot(0, {2'b00, 16'h0403, 2'd0}, m0);
        expect_true(!m0, "slot 0 repeat read went to sdram");
        read_slot(0, {2'b00, 16'h0302, 2'd1}, m0);
        expect_true(!m0, "slot 0 repeat read went to sdram");
        read_slot(1, {19'h7ffff, 1'b0}, m1);
        expect_true(!m1, "slot 1 repeat read went to sdram");
        read_slot(1, {19'h2a000, 1'b1}, m1);
        expect_true(!m1, "slot 1 repeat read went to sdram");
        report_test(3, "hits", e);

        // a, b, c then a is gone and c stays
        e = errors;
        read_slot(0, {2'b00, 16'h5000, 2'd0}, m0);
        read_slot(0, {2'b00, 16'h5001, 2'd0}, m0);
        read_slot(0, {2'b00, 16'h5002, 2'd0}, m0);
        read_slot(0, {2'b00, 16'h5000, 2'd2}, m0);
        expect_true(m0, "evicted word was served without sdram");
        read_slot(0, {2'b00, 16'h5002, 2'd3}, m0);
        expect_true(!m0, "recent word went to sdram again");
        report_test(4, "replacement", e);

        // both slots miss in the same cycle
        e = errors;
        fork
            read_slot(0, {2'b00, 16'h6000, 2'd1}, m0);
            read_slot(1, {19'h31234, 1'b0}, m1);
        join
        expect_true(m0 && m1, "simultaneous misses not both fetched");
        report_test(5, "simultaneous misses", e);

        // random mix, small word pools so hits and misses both occur
        e = errors;
        for (int i = 0; i < 100; i++) begin
            r       = $random(seed);
            rnd0[i] = {2'b00, 16'h3000 + 16'(r[1:0]) * 16'h0951, r[9:8]};
            rnd1[i] = {19'h40000 + 19'(r[17:16]) * 19'h0a3d, r[20]};
        end
        fork
            begin
                for (int i = 0; i < 100; i++) read_slot(0, rnd0[i], m0);
            end
            begin
                for (int j = 0; j < 100; j++) read_slot(1, rnd1[j], m1);
            end
        join
        report_test(6, "random mix", e);

        $display("tests run: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // bound on the whole run, generous per read
    initial begin
        repeat (READ_COUNT * 200) @(posedge clk);
        $display("run did not finish within %0d cycles", READ_COUNT * 200);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== tb/sdram_model.sv ====
// sdram model: read-only sdram port with random ack and data latency, contents from a formula
`timescale 1ns/10ps

module sdram_model #(
    parameter int SEED = 32'h3f7cc304       // start of the latency stream
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req,    // held until ack
    input  logic [rom_pkg::SDRAM_AW-1:0] addr,
    output logic                         ack,    // one-cycle, request taken
    output logic                         rdy,    // one-cycle, dout valid
    output rom_pkg::word_t               dout
);
    import rom_pkg::*;

    integer      seed;
    int          ack_dly;      // cycles from request to ack, 1..4
    int          rdy_dly;      // cycles from ack to rdy, 2..6
    sdram_addr_t addr_q;

    // contents: word address xor a marker, plus the address moved up by 10
    function automatic word_t stored_word(input sdram_addr_t wa);
        word_t w;
        w = word_t'(wa);
        return (w ^ 32'h5a5a0000) + (w << 10);
    endfunction

    initial begin
        seed = SEED;
        ack  = 1'b0;
        rdy  = 1'b0;
        dout = '0;
        forever begin
            @(negedge clk);                      // req is a register, stable here
            if (!rst && req) begin
                addr_q  = addr;
                ack_dly = 1 + ($unsigned($random(seed)) % 4);
                rdy_dly = 2 + ($unsigned($random(seed)) % 5);
                repeat (ack_dly) @(posedge clk);
                #1 ack = 1'b1;
                @(posedge clk);
                #1 ack = 1'b0;
                repeat (rdy_dly - 1) @(posedge clk);
                #1;
                rdy  = 1'b1;
                dout = stored_word(addr_q);      // only one fetch in flight
                @(posedge clk);
                #1 rdy = 1'b0;
            end
        end
    end

endmodule

// ==== hw/rom_fetch_top.sv ====
// rom fetch top: program and graphics rom caches sharing one sdram read port
`timescale 1ns/10ps

module rom_fetch_top #(
    parameter int ROM0_AW     = 18,         // cpu program rom, byte addressed
    parameter int ROM0_DW     = 8,
    parameter int ROM0_OFFSET = 0,
    parameter int ROM1_AW     = 20,         // graphics rom, halfword addressed
    parameter int ROM1_DW     = 16,
    parameter int ROM1_OFFSET = 22'h10000
) (
    input  logic                         clk,
    input  logic                         rst,
    // slot 0 client
    input  logic [ROM0_AW-1:0]           rom0_addr,
    input  logic                         rom0_addr_ok,
    output logic [ROM0_DW-1:0]           rom0_data,
    output logic                         rom0_data_ok,
    // slot 1 client
    input  logic [ROM1_AW-1:0]           rom1_addr,
    input  logic                         rom1_addr_ok,
    output logic [ROM1_DW-1:0]           rom1_data,
    output logic                         rom1_data_ok,
    // sdram read port
    output logic                         sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0] sdram_addr,
    input  logic                         sdram_ack,
    input  logic                         sdram_rdy,
    input  rom_pkg::word_t               sdram_dout
);

    rom_slot_if slot0_if ();    // program rom cache to arbiter
    rom_slot_if slot1_if ();    // graphics rom cache to arbiter

    rom_cache #(
        .AW     (ROM0_AW),
        .DW     (ROM0_DW),
        .OFFSET (ROM0_OFFSET)
    ) u_cache0 (
        .clk     (clk),
        .rst     (rst),
        .addr    (rom0_addr),
        .addr_ok (rom0_addr_ok),
        .data    (rom0_data),
        .data_ok (rom0_data_ok),
        .slot    (slot0_if.cache)
    );

    rom_cache #(
        .AW     (ROM1_AW),
        .DW     (ROM1_DW),
        .OFFSET (ROM1_OFFSET)
    ) u_cache1 (
        .clk     (clk),
        .rst     (rst),
        .addr    (rom1_addr),
        .addr_ok (rom1_addr_ok),
        .data    (rom1_data),
        .data_ok (rom1_data_ok),
        .slot    (slot1_if.cache)
    );

    rom_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .slot0      (slot0_if.arbiter),
        .slot1      (slot1_if.arbiter),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .sdram_rdy  (sdram_rdy),
        .sdram_dout (sdram_dout)
    );

endmodule

// ==== hw/rom_arbiter.sv ====
// rom arbiter: shares one sdram read port between two cache slots, alternating on contention
`timescale 1ns/10ps

module rom_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    rom_slot_if.arbiter          slot0,
    rom_slot_if.arbiter          slot1,
    output logic                 sdram_req,    // held until sdram_ack
    output rom_pkg::sdram_addr_t sdram_addr,   // stable while sdram_req is high
    input  logic                 sdram_ack,    // one-cycle, request taken
    input  logic                 sdram_rdy,    // one-cycle, sdram_dout valid
    input  rom_pkg::word_t       sdram_dout
);
    import rom_pkg::*;

    arb_state_t state;
    logic       owner;      // slot granted last, also the slot in flight
    logic       any_req;
    logic       pick;       // slot to grant in idle
    logic [1:0] we_r;       // port ownership, one bit per slot
    logic [1:0] ok_r;       // din_ok strobes
    word_t      din_r;

    assign any_req = slot0.req || slot1.req;

    // both asking: take the one not served last
    assign pick = (slot0.req && slot1.req) ? !owner : slot1.req;

    // main FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ARB_IDLE;
            sdram_req <= 1'b0;
            owner     <= 1'b1;          // so slot 0 wins the first tie
            we_r      <= 2'b00;
            ok_r      <= 2'b00;
        end else begin
            ok_r <= 2'b00;              // strobe
            we_r <= we_r & ~ok_r;       // ownership ends with the din_ok cycle
            case (state)
                ARB_IDLE: begin
                    // may grant during the previous owner's din_ok cycle
                    if (any_req) begin
                        owner      <= pick;
                        we_r[pick] <= 1'b1;
                        sdram_req  <= 1'b1;
                        state      <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (sdram_rdy) begin
                        ok_r[owner] <= 1'b1;   // only the owner sees the strobe
                        state       <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // address latched at grant, data latched at rdy
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && any_req) begin
            sdram_addr <= pick ? slot1.sdram_addr : slot0.sdram_addr;
        end
        if (state == ARB_WAIT_DATA && sdram_rdy) begin
            din_r <= sdram_dout;
        end
    end

    // returned word is broadcast, din_ok tells who it is for
    assign slot0.din    = din_r;
    assign slot1.din    = din_r;
    assign slot0.we     = we_r[0];
    assign slot1.we     = we_r[1];
    assign slot0.din_ok = ok_r[0];
    assign slot1.din_ok = ok_r[1];

endmodule

// ==== hw/rom_cache.sv ====
// rom cache: two-entry word cache in front of one rom client, fetches misses over a slot
`timescale 1ns/10ps

module rom_cache #(
    parameter int AW     = 18,      // client address width
    parameter int DW     = 8,       // client data width, 8, 16 or 32
    parameter int OFFSET = 0        // sdram word offset of this rom region
) (
    input  logic          clk,
    input  logic          rst,
    input  logic [AW-1:0] addr,
    input  logic          addr_ok,  // addr is valid, held until data_ok
    output logic [DW-1:0] data,
    output logic          data_ok,  // one-cycle strobe, data valid now
    rom_slot_if.cache     slot
);
    import rom_pkg::*;

    // client address bits that select inside a 32-bit word
    localparam int SHIFT = (DW == 8) ? 2 : (DW == 16) ? 1 : 0;
    localparam int WAW   = AW - SHIFT;  // word address width

    logic [WAW-1:0] word_addr;  // client address aligned to a word
    logic [WAW-1:0] pend_addr;  // word address taken by the arbiter at grant
    logic [WAW-1:0] tag0;
    logic [WAW-1:0] tag1;
    word_t          line0;
    word_t          line1;
    word_t          data_mux;
    logic           init;       // nothing cached yet
    logic           victim;     // entry replaced by the next fill
    logic           hit0;
    logic           hit1;
    logic           hit;
    logic           fill;       // returned word is ours this cycle

    assign word_addr = addr[AW-1:SHIFT];

    // tags are meaningless until the first fill
    assign hit0 = !init && addr_ok && (word_addr == tag0);
    assign hit1 = !init && addr_ok && (word_addr == tag1);
    assign hit  = hit0 || hit1;
    assign fill = slot.we && slot.din_ok;

    // miss request, dropped while our fetch is in flight
    assign slot.req        = addr_ok && !hit && !slot.we;
    assign slot.sdram_addr = sdram_addr_t'(word_addr) + sdram_addr_t'(OFFSET);

    // follow the address until the arbiter grants us, then freeze it
    // so the fill lands under the tag that was actually fetched
    always_ff @(posedge clk) begin
        if (!slot.we) begin
            pend_addr <= word_addr;
        end
    end

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init    <= 1'b1;
            victim  <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            // strobe for one cycle, then rearm for the next access
            data_ok <= !data_ok && addr_ok &&
                       (hit || (fill && (word_addr == pend_addr)));
            if (fill) begin
                init <= 1'b0;
                if (!init) begin
                    victim <= ~victim;  // alternate between the two entries
                end
            end
        end
    end

    // cached words and their tags
    always_ff @(posedge clk) begin
        if (fill) begin
            if (init || !victim) begin
                tag0  <= pend_addr;
                line0 <= slot.din;
            end
            if (init || victim) begin  // first fill loads both entries
                tag1  <= pend_addr;
                line1 <= slot.din;
            end
        end
    end

    // fresh word goes straight through during the fill cycle
    assign data_mux = fill ? slot.din : (hit0 ? line0 : line1);

    // sub-word select, little endian inside the word
    generate
        if (DW == 8) begin : g_byte
            always_comb begin
                case (addr[1:0])
                    2'd0:    data = data_mux[7:0];
                    2'd1:    data = data_mux[15:8];
                    2'd2:    data = data_mux[23:16];
                    default: data = data_mux[31:24];
                endcase
            end
        end else if (DW == 16) begin : g_half
            always_comb begin
                if (addr[0]) begin
                    data = data_mux[31:16];   // upper halfword
                end else begin
                    data = data_mux[15:0];
                end
            end
        end else begin : g_word
            assign data = data_mux;           // whole word, no select
        end
    endgenerate

endmodule

// ==== hw/rom_slot_if.sv ====
// rom slot interface: links one rom cache to its port on the sdram arbiter
`timescale 1ns/10ps

interface rom_slot_if;
    import rom_pkg::*;

    logic        req;          // level, cache wants its word fetched
    sdram_addr_t sdram_addr;   // word address, region offset already added
    word_t       din;          // returned word, shared by all slots
    logic        we;           // level, this slot owns the sdram port
    logic        din_ok;       // one-cycle strobe, din belongs to this slot

    // cache side
    modport cache (
        output req,
        output sdram_addr,
        input  din,
        input  we,
        input  din_ok
    );

    // arbiter side
    modport arbiter (
        input  req,
        input  sdram_addr,
        output din,
        output we,
        output din_ok
    );

endinterface

// ==== hw/rom_pkg.sv ====
// rom fetch package: sdram word and address types shared by the caches and the arbiter
package rom_pkg;

    // sdram geometry
    // the sdram is seen as an array of 32-bit words, addressed by word
    localparam int SDRAM_AW = 22;          // word address width
    localparam int WORD_W   = 32;          // one sdram word

    // word address as it travels from a cache to the sdram port
    typedef logic [SDRAM_AW-1:0] sdram_addr_t;

    // one data word as returned by the sdram
    typedef logic [WORD_W-1:0] word_t;

    // arbiter FSM
    // idle       : looking at both slot requests
    // wait_ack   : sdram_req held high with a stable address
    // wait_data  : request accepted, waiting for sdram_rdy
    typedef enum logic [1:0] {
        ARB_IDLE      = 2'd0,
        ARB_WAIT_ACK  = 2'd1,
        ARB_WAIT_DATA = 2'd2
    } arb_state_t;

endpackage
